/* hdl/sdram_burst_test_consts.svh */
`ifndef SDRAM_BURST_TEST_CONSTS_SVH
`define SDRAM_BURST_TEST_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Burst memory tester constants.
////////////////////////////////////////////////////////////////////////////

// Words moved per memory request.
`define BURST_WORDS 4

// 133.333 MHz / 115200 baud.
// Rounds to 1157 clocks per bit and fits in 11 bits.
`define BAUD_DIV_133M 1157

// One 480 x 800 screen of pixels.
`define FRAME_WORDS_DEFAULT 384000 // 24-bit address space.

// Pause after each reported burst.
`define DWELL_DEFAULT 2222222 // Roughly 16.7 ms at 133 MHz.

////////////////////////////////////////////////////////////////////////////
// UART framing.
////////////////////////////////////////////////////////////////////////////

// Start bit, 8 data bits LSB first, 2 stop bits.
`define UART_FRAME_BITS 11

`endif

/* hdl/sdram_burst_test_pkg.sv */
`default_nettype none
`include "sdram_burst_test_consts.svh"

package sdram_burst_test_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Memory side.
    ////////////////////////////////////////////////////////////////////////////

    // One 16-bit memory word.
    typedef logic [15:0] word_t;

    // Word 0 sits in the top bits.
    typedef word_t [0:`BURST_WORDS-1] burst_t; // 64 bits.

    // Bank 2 + row 13 + column 9.
    // Kept flat so the address steps by plain adds.
    typedef logic [23:0] addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // UART side.
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [7:0] byte_t; // One payload byte.

endpackage

`default_nettype wire

/* hdl/uart_tx.sv */
`timescale 1ns/1ns
`default_nettype none
`include "sdram_burst_test_consts.svh"

module uart_tx #(
    parameter int BAUD_DIV = `BAUD_DIV_133M // Clocks per bit.
) (
    input  wire                              clk_133MHz_210,
    input  wire                              rst_n,
    input  wire                              tx_start, // One-cycle pulse.
    input  wire sdram_burst_test_pkg::byte_t tx_byte,
    output logic                             uart_txd,
    output logic                             tx_busy
);

    localparam int BAUD_W = $clog2(BAUD_DIV);
    localparam int BIT_W  = $clog2(`UART_FRAME_BITS);
    localparam int STOP_BITS = `UART_FRAME_BITS - 9; // Minus start and data.

    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(BAUD_DIV - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(`UART_FRAME_BITS - 1);

    logic [BAUD_W-1:0]            baud_cnt; // Clocks within a bit.
    logic [BIT_W-1:0]             bit_cnt;  // Bit within the frame.
    logic [`UART_FRAME_BITS-2:0]  shreg;    // Data then stop bits.

    // Frame payload. Start bit goes straight to the pin.
    always_ff @(posedge clk_133MHz_210) begin
        if (tx_start && !tx_busy) begin
            shreg <= {{STOP_BITS{1'b1}}, tx_byte};
        end else if (tx_busy && baud_cnt == BAUD_LAST) begin
            shreg <= {1'b1, shreg[`UART_FRAME_BITS-2:1]}; // Shift in idle level.
        end
    end

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            uart_txd <= 1'b1; // Line idles high.
            tx_busy  <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                uart_txd <= 1'b0; // Start bit.
                tx_busy  <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (baud_cnt == BAUD_LAST) begin
            baud_cnt <= '0;
            if (bit_cnt == BIT_LAST) begin
                // Last stop bit done.
                tx_busy  <= 1'b0;
                uart_txd <= 1'b1;
            end else begin
                bit_cnt  <= bit_cnt + 1'b1;
                uart_txd <= shreg[0]; // LSB first.
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // A start during a frame would be lost.
    a_no_start_while_busy: assert property (
        @(posedge clk_133MHz_210) disable iff (!rst_n)
        tx_start |-> !tx_busy
    );

endmodule

`default_nettype wire

/* hdl/readback_reporter.sv */
`timescale 1ns/1ns
`default_nettype none
`include "sdram_burst_test_consts.svh"

module readback_reporter (
    input  wire                               clk_133MHz_210,
    input  wire                               rst_n,
    input  wire                               report_start, // One-cycle pulse.
    input  wire sdram_burst_test_pkg::burst_t expected,     // Written burst.
    input  wire sdram_burst_test_pkg::burst_t captured,     // Read-back burst.
    input  wire                               tx_busy,
    output logic                              tx_start,
    output sdram_burst_test_pkg::byte_t       tx_byte,
    output logic                              report_done,
    output logic                              report_fail
);

    import sdram_burst_test_pkg::*;

    localparam int NBYTES = 2 * `BURST_WORDS;  // Two bytes per word.
    localparam int IDX_W  = $clog2(NBYTES);

    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(NBYTES - 1);

    typedef enum logic [2:0] {
        R_IDLE,    // Waiting for a burst.
        R_CHECK,   // Word compare.
        R_SEND,    // Waiting on the UART.
        R_ADVANCE, // Next byte.
        R_DRAIN    // Last frame still on the line.
    } rstate_t;

    rstate_t          state;
    logic [IDX_W-1:0] idx;      // Byte index.
    word_t            cur_word; // Word under the index.
    word_t            exp_word;
    logic             word_ok;

    ////////////////////////////////////////////////////////////////////////////
    // Word select and compare.
    ////////////////////////////////////////////////////////////////////////////

    assign cur_word = captured[idx[IDX_W-1:1]];
    assign exp_word = expected[idx[IDX_W-1:1]];
    assign word_ok  = (cur_word == exp_word);

    // Payload byte. High half at even index.
    always_ff @(posedge clk_133MHz_210) begin
        if (state == R_SEND && !tx_busy) begin
            tx_byte <= idx[0] ? cur_word[7:0] : cur_word[15:8];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Byte walk.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state       <= R_IDLE;
            idx         <= '0;
            tx_start    <= 1'b0;
            report_done <= 1'b0;
            report_fail <= 1'b0;
        end else begin
            tx_start    <= 1'b0; // Pulses by default.
            report_done <= 1'b0;
            report_fail <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (report_start) begin
                        idx   <= '0;
                        state <= R_CHECK;
                    end
                end
                R_CHECK: begin
                    if (word_ok) begin
                        state <= R_SEND;
                    end else begin
                        report_fail <= 1'b1; // Bad word is never sent.
                        state       <= R_IDLE;
                    end
                end
                R_SEND: begin
                    if (!tx_busy) begin
                        tx_start <= 1'b1;
                        state    <= R_ADVANCE; // Gives busy a cycle to rise.
                    end
                end
                R_ADVANCE: begin
                    if (idx == IDX_LAST) begin
                        state <= R_DRAIN;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= idx[0] ? R_CHECK : R_SEND; // Even index next.
                    end
                end
                R_DRAIN: begin
                    if (!tx_busy) begin
                        report_done <= 1'b1;
                        state       <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // UART busy is one cycle late. The walk must cover that gap.
    a_start_only_when_idle: assert property (
        @(posedge clk_133MHz_210) disable iff (!rst_n)
        tx_start |-> !tx_busy
    );

endmodule

`default_nettype wire

/* hdl/test_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "sdram_burst_test_consts.svh"

module test_sequencer #(
    parameter int FRAME_WORDS = `FRAME_WORDS_DEFAULT, // Words tested.
    parameter int DWELL       = `DWELL_DEFAULT        // Clocks between bursts.
) (
    input  wire                               clk_133MHz_210,
    input  wire                               rst_n,
    input  wire                               mem_wr_done,  // Pulse.
    input  wire                               mem_rd_done,  // Pulse.
    input  wire sdram_burst_test_pkg::burst_t mem_rd_data,
    input  wire                               report_done,
    input  wire                               report_fail,
    output logic [1:0]                        mem_req,      // [1] write, [0] read.
    output sdram_burst_test_pkg::addr_t       mem_addr,
    output sdram_burst_test_pkg::burst_t      mem_wr_data,
    output logic                              report_start,
    output sdram_burst_test_pkg::burst_t      expected,
    output sdram_burst_test_pkg::burst_t      captured,
    output logic                              led           // Sticky fail.
);

    import sdram_burst_test_pkg::*;

    typedef enum logic [2:0] {
        S_WRITE,   // Write request held.
        S_READ,    // Read request held.
        S_REPORT,  // Reporter busy.
        S_DWELL,
        S_ADVANCE,
        S_HALT,    // Mismatch seen.
        S_STOP     // Frame finished.
    } sstate_t;

    // Start of the last burst in the frame.
    localparam addr_t       LAST_ADDR  = addr_t'(FRAME_WORDS - `BURST_WORDS);
    localparam addr_t       ADDR_STEP  = addr_t'(`BURST_WORDS);
    localparam logic [31:0] DWELL_LAST = 32'(DWELL - 1);

    sstate_t     state;
    word_t       pattern;   // Value in every word of this burst.
    logic [31:0] dwell_cnt;

    // All words of a burst carry the same pattern.
    assign mem_wr_data = {`BURST_WORDS{pattern}};
    assign expected    = mem_wr_data; // Steady until advance.

    // Read data only valid with its done pulse.
    always_ff @(posedge clk_133MHz_210) begin
        if (state == S_READ && mem_rd_done) begin
            captured <= mem_rd_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Burst state machine.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_WRITE; // Write goes out right after reset.
            mem_req      <= 2'b00;
            mem_addr     <= '0;
            pattern      <= '0;
            dwell_cnt    <= '0;
            report_start <= 1'b0;
            led          <= 1'b0;
        end else begin
            report_start <= 1'b0;
            case (state)
                S_WRITE: begin
                    if (mem_wr_done) begin
                        mem_req[1] <= 1'b0;
                        state      <= S_READ;
                    end else begin
                        mem_req[1] <= 1'b1; // Hold until done.
                    end
                end
                S_READ: begin
                    if (mem_rd_done) begin
                        mem_req[0]   <= 1'b0;
                        report_start <= 1'b1; // Captured is valid next cycle.
                        state        <= S_REPORT;
                    end else begin
                        mem_req[0] <= 1'b1;
                    end
                end
                S_REPORT: begin
                    if (report_fail) begin
                        led   <= 1'b1;
                        state <= S_HALT;
                    end else if (report_done) begin
                        dwell_cnt <= '0;
                        state     <= S_DWELL;
                    end
                end
                S_DWELL: begin
                    if (dwell_cnt == DWELL_LAST) begin
                        state <= S_ADVANCE;
                    end else begin
                        dwell_cnt <= dwell_cnt + 1'b1;
                    end
                end
                S_ADVANCE: begin
                    if (mem_addr == LAST_ADDR) begin
                        state <= S_STOP;
                    end else begin
                        mem_addr <= mem_addr + ADDR_STEP; // Next burst.
                        pattern  <= pattern + 1'b1;
                        state    <= S_WRITE;
                    end
                end
                S_HALT:  state <= S_HALT;  // Only reset leaves.
                S_STOP:  state <= S_STOP;
                default: state <= S_HALT;
            endcase
        end
    end

    // Memory port takes one command at a time.
    a_req_exclusive: assert property (
        @(posedge clk_133MHz_210) disable iff (!rst_n)
        !(mem_req[1] && mem_req[0])
    );

endmodule

`default_nettype wire

/* hdl/sdram_burst_test.sv */
`timescale 1ns/1ns
`default_nettype none
`include "sdram_burst_test_consts.svh"

module sdram_burst_test #(
    parameter int BAUD_DIV    = `BAUD_DIV_133M,       // Clocks per UART bit.
    parameter int FRAME_WORDS = `FRAME_WORDS_DEFAULT, // Words tested.
    parameter int DWELL       = `DWELL_DEFAULT        // Clocks between bursts.
) (
    input  wire                               clk_133MHz_210,
    input  wire                               rst_n,
    input  wire                               mem_wr_done,
    input  wire                               mem_rd_done,
    input  wire sdram_burst_test_pkg::burst_t mem_rd_data,
    output logic [1:0]                        mem_req,     // [1] write, [0] read.
    output sdram_burst_test_pkg::addr_t       mem_addr,
    output sdram_burst_test_pkg::burst_t      mem_wr_data,
    output logic                              uart_txd,
    output logic                              led          // Lit on mismatch.
);

    import sdram_burst_test_pkg::*;

    logic   report_start;
    logic   report_done;
    logic   report_fail;
    burst_t expected; // Written burst.
    burst_t captured; // Read-back burst.
    logic   tx_start;
    byte_t  tx_byte;
    logic   tx_busy;

    ////////////////////////////////////////////////////////////////////////////
    // Burst control and memory port.
    ////////////////////////////////////////////////////////////////////////////

    test_sequencer #(
        .FRAME_WORDS (FRAME_WORDS),
        .DWELL       (DWELL)
    ) u_sequencer (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .mem_wr_done    (mem_wr_done),
        .mem_rd_done    (mem_rd_done),
        .mem_rd_data    (mem_rd_data),
        .report_done    (report_done),
        .report_fail    (report_fail),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_wr_data    (mem_wr_data),
        .report_start   (report_start),
        .expected       (expected),
        .captured       (captured),
        .led            (led)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Compare and serial report.
    ////////////////////////////////////////////////////////////////////////////

    readback_reporter u_reporter (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .report_start   (report_start),
        .expected       (expected),
        .captured       (captured),
        .tx_busy        (tx_busy),
        .tx_start       (tx_start),
        .tx_byte        (tx_byte),
        .report_done    (report_done),
        .report_fail    (report_fail)
    );

    uart_tx #(
        .BAUD_DIV (BAUD_DIV)
    ) u_uart_tx (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .tx_start       (tx_start),
        .tx_byte        (tx_byte),
        .uart_txd       (uart_txd),
        .tx_busy        (tx_busy)
    );

endmodule

`default_nettype wire

/* dv/tb_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none
`include "sdram_burst_test_consts.svh"

module tb_mem_model #(
    parameter int DEPTH = 16 // Words held.
) (
    input  wire                               clk_133MHz_210,
    input  wire                               rst_n,
    input  wire [1:0]                         mem_req,      // [1] write, [0] read.
    input  wire sdram_burst_test_pkg::addr_t  mem_addr,
    input  wire sdram_burst_test_pkg::burst_t mem_wr_data,
    input  wire                               corrupt,      // Arms the bad read.
    input  wire sdram_burst_test_pkg::addr_t  corrupt_addr, // Burst that gets it.
    output logic                              mem_wr_done,
    output logic                              mem_rd_done,
    output sdram_burst_test_pkg::burst_t      mem_rd_data
);

    import sdram_burst_test_pkg::*;

    localparam int AW   = $clog2(DEPTH);
    localparam int WSEL = $clog2(`BURST_WORDS);

    word_t       mem [0:DEPTH-1];
    logic [31:0] rng; // Latency source.
    int          lat;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Request responder.
    ////////////////////////////////////////////////////////////////////////////

    initial begin : responder
        logic [AW-1:0] wa;
        for (int i = 0; i < DEPTH; i++) begin
            mem[AW'(i)] = 16'h5a5a ^ word_t'(i * 257); // Unwritten words look distinct.
        end
        mem_wr_done = 1'b0;
        mem_rd_done = 1'b0;
        mem_rd_data = '0;
        rng         = 32'h30194cdd;
        forever begin
            @(posedge clk_133MHz_210);
            #1;
            if (rst_n && mem_req != 2'b00) begin
                rng = xorshift32(rng);
                lat = int'(rng % 32'd8) + 1; // 1 to 8 cycles.
                repeat (lat) @(posedge clk_133MHz_210);
                #1;
                if (rst_n && mem_req[1]) begin
                    for (int i = 0; i < `BURST_WORDS; i++) begin
                        wa      = AW'(mem_addr) + AW'(i);
                        mem[wa] = mem_wr_data[WSEL'(i)];
                    end
                    mem_wr_done = 1'b1;
                end else if (rst_n && mem_req[0]) begin
                    for (int i = 0; i < `BURST_WORDS; i++) begin
                        wa                       = AW'(mem_addr) + AW'(i);
                        mem_rd_data[WSEL'(i)] = mem[wa];
                    end
                    if (corrupt && mem_addr == corrupt_addr) begin
                        mem_rd_data[1] = mem_rd_data[1] ^ 16'h0040; // Word 1, one bit.
                    end
                    mem_rd_done = 1'b1;
                end
                @(posedge clk_133MHz_210);
                #1;
                mem_wr_done = 1'b0; // One-cycle pulse.
                mem_rd_done = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/sdram_burst_test_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "sdram_burst_test_consts.svh"

module sdram_burst_test_tb;

    import sdram_burst_test_pkg::*;

    localparam int BAUD_DIV    = 8;
    localparam int FRAME_WORDS = 16; // Four bursts.
    localparam int DWELL       = 20;
    localparam int BURSTS      = FRAME_WORDS / `BURST_WORDS;
    localparam int FRAME_CLKS  = `UART_FRAME_BITS * BAUD_DIV;
    // Eight frames, dwell and memory waits per burst, doubled.
    localparam int RUN_LIMIT   = BURSTS * (8 * FRAME_CLKS + DWELL + 2 * 8 + 10) * 2;
    localparam int CYCLE_LIMIT = 2 * RUN_LIMIT; // Two runs.
    localparam int QUIET       = 4 * DWELL;     // Window for stray requests.

    logic       clk_133MHz_210;
    logic       rst_n;
    logic       mem_wr_done;
    logic       mem_rd_done;
    burst_t     mem_rd_data;
    logic [1:0] mem_req;
    addr_t      mem_addr;
    burst_t     mem_wr_data;
    logic       uart_txd;
    logic       led;
    logic       corrupt;
    int         value_errors = 0;
    int         other_errors = 0;
    int         rx_count     = 0; // Bytes decoded this run.
    int         wr_count     = 0;
    int         rd_count     = 0;

    sdram_burst_test #(
        .BAUD_DIV    (BAUD_DIV),
        .FRAME_WORDS (FRAME_WORDS),
        .DWELL       (DWELL)
    ) DUT (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .mem_wr_done    (mem_wr_done),
        .mem_rd_done    (mem_rd_done),
        .mem_rd_data    (mem_rd_data),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_wr_data    (mem_wr_data),
        .uart_txd       (uart_txd),
        .led            (led)
    );

    tb_mem_model #(
        .DEPTH (FRAME_WORDS)
    ) u_mem (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_wr_data    (mem_wr_data),
        .corrupt        (corrupt),
        .corrupt_addr   (addr_t'(2 * `BURST_WORDS)), // Burst 2.
        .mem_wr_done    (mem_wr_done),
        .mem_rd_done    (mem_rd_done),
        .mem_rd_data    (mem_rd_data)
    );

    task automatic mismatch_error(input string name, input logic [63:0] exp,
                                  input logic [63:0] act);
        value_errors++;
        $display("Error %s: expected 0x%0h, actual 0x%0h (t=%0t)", name, exp, act, $time);
    endtask

    task automatic check_failure(input string what);
        other_errors++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    task automatic end_simulation();
        $display("Errors: %0d value, %0d other, %0d total", value_errors, other_errors,
                 value_errors + other_errors);
        if (value_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // Burst n/8 holds n/8 in every word. High byte is zero.
    function automatic byte_t expected_byte(input int n);
        if (n % 2 == 0) begin
            return 8'h00;
        end else begin
            return byte_t'(n / 8);
        end
    endfunction

    task automatic hold_reset();
        rst_n = 1'b0;
        repeat (16) @(posedge clk_133MHz_210);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic check_run(input string run, input int bursts, input int bytes,
                             input logic led_exp);
        assert (wr_count == bursts)
            else mismatch_error({run, "_writes"}, 64'(bursts), 64'(wr_count));
        assert (rd_count == bursts)
            else mismatch_error({run, "_reads"}, 64'(bursts), 64'(rd_count));
        assert (rx_count == bytes)
            else mismatch_error({run, "_bytes"}, 64'(bytes), 64'(rx_count));
        assert (led == led_exp) else mismatch_error({run, "_led"}, 64'(led_exp), 64'(led));
        assert (mem_req == 2'b00) else mismatch_error({run, "_idle_req"}, 64'(0), 64'(mem_req));
    endtask

    task automatic check_first_write(input string run);
        @(posedge clk_133MHz_210);
        assert (mem_req == 2'b00) else mismatch_error({run, "_req_at_release"}, 0, 64'(mem_req));
        @(posedge clk_133MHz_210);
        assert (mem_req == 2'b10) else mismatch_error({run, "_first_write"}, 2, 64'(mem_req));
    endtask

    initial begin : clock_gen
        clk_133MHz_210 = 1'b0;
        forever #5 clk_133MHz_210 = ~clk_133MHz_210;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Runs.
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        rst_n   = 1'b1;
        corrupt = 1'b0;
        #1;
        hold_reset(); // Negedge makes the async reset fire.
        check_first_write("clean");
        wait (rx_count == 8 * BURSTS);
        repeat (QUIET) @(posedge clk_133MHz_210);
        check_run("clean", BURSTS, 8 * BURSTS, 1'b0);

        // Run 2, word 1 of burst 2 reads back wrong.
        @(posedge clk_133MHz_210);
        #1;
        corrupt = 1'b1;
        hold_reset();
        check_first_write("corrupt");
        wait (led == 1'b1);
        repeat (2 * FRAME_CLKS + QUIET) @(posedge clk_133MHz_210); // Last byte still on line.
        check_run("corrupt", 3, 8 * 2 + 2, 1'b1);
        end_simulation();
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk_133MHz_210);
            cycles++;
        end
        check_failure($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
        end_simulation();
    end

    ////////////////////////////////////////////////////////////////////////////
    // UART decoder. Samples mid-bit.
    ////////////////////////////////////////////////////////////////////////////

    initial begin : uart_decoder
        byte_t rx;
        int    i;
        forever begin
            @(posedge clk_133MHz_210);
            if (!rst_n) begin
                rx_count = 0;
            end else if (uart_txd == 1'b0) begin
                repeat (BAUD_DIV / 2 - 1) @(posedge clk_133MHz_210); // Middle of start.
                assert (uart_txd == 1'b0) else mismatch_error("uart_start_bit", 0, 64'(uart_txd));
                for (i = 0; i < 8; i++) begin
                    repeat (BAUD_DIV) @(posedge clk_133MHz_210);
                    rx[3'(i)] = uart_txd; // LSB first.
                end
                for (i = 0; i < 2; i++) begin
                    repeat (BAUD_DIV) @(posedge clk_133MHz_210);
                    assert (uart_txd == 1'b1)
                        else mismatch_error("uart_stop_bit", 1, 64'(uart_txd));
                end
                assert (rx == expected_byte(rx_count))
                    else mismatch_error($sformatf("uart_byte_%0d", rx_count),
                                        64'(expected_byte(rx_count)), 64'(rx));
                rx_count++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory request monitor.
    ////////////////////////////////////////////////////////////////////////////

    initial begin : request_monitor
        logic [1:0]  prev;
        logic        wr_seen; // Done seen while held.
        logic        rd_seen;
        logic [63:0] exp_data;
        prev    = 2'b00;
        wr_seen = 1'b0;
        rd_seen = 1'b0;
        forever begin
            @(posedge clk_133MHz_210);
            if (!rst_n) begin
                wr_count = 0;
                rd_count = 0;
                prev     = 2'b00;
                wr_seen  = 1'b0;
                rd_seen  = 1'b0;
            end else begin
                wr_seen = wr_seen | (mem_req[1] & mem_wr_done);
                rd_seen = rd_seen | (mem_req[0] & mem_rd_done);
                if (mem_req[1] && !prev[1]) begin
                    exp_data = {`BURST_WORDS{16'(wr_count)}}; // Burst k, all words k.
                    assert (mem_addr == addr_t'(`BURST_WORDS * wr_count))
                        else mismatch_error("write_addr", 64'(`BURST_WORDS * wr_count),
                                            64'(mem_addr));
                    assert (mem_wr_data == exp_data)
                        else mismatch_error("write_data", exp_data, 64'(mem_wr_data));
                    wr_count++;
                end
                if (mem_req[0] && !prev[0]) begin
                    assert (mem_addr == addr_t'(`BURST_WORDS * (wr_count - 1)))
                        else mismatch_error("read_addr", 64'(`BURST_WORDS * (wr_count - 1)),
                                            64'(mem_addr));
                    rd_count++;
                end
                if (prev[1] && !mem_req[1]) begin
                    assert (wr_seen) else check_failure("write request dropped before done");
                    wr_seen = 1'b0;
                end
                if (prev[0] && !mem_req[0]) begin
                    assert (rd_seen) else check_failure("read request dropped before done");
                    rd_seen = 1'b0;
                end
                prev = mem_req;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Protocol assertions.
    ////////////////////////////////////////////////////////////////////////////

    a_req_exclusive: assert property (
        @(posedge clk_133MHz_210) disable iff (!rst_n)
        !(mem_req[1] && mem_req[0])
    ) else check_failure("write and read requests high together");

    a_reset_idle: assert property (
        @(posedge clk_133MHz_210)
        !rst_n |-> (mem_req == 2'b00 && uart_txd && !led)
    ) else check_failure("outputs not idle during reset");

    a_led_clean: assert property (
        @(posedge clk_133MHz_210) disable iff (!rst_n)
        !corrupt |-> !led
    ) else check_failure("led lit in the clean run");

    a_led_sticky: assert property (
        @(posedge clk_133MHz_210) disable iff (!rst_n)
        $past(led) |-> led
    ) else check_failure("led dropped after a mismatch");

    a_halt_quiet: assert property (
        @(posedge clk_133MHz_210) disable iff (!rst_n)
        led |-> mem_req == 2'b00
    ) else check_failure("memory request raised after the halt");

endmodule

`default_nettype wire

/* sdram_burst_test.f */
+incdir+hdl
hdl/sdram_burst_test_pkg.sv
hdl/uart_tx.sv
hdl/readback_reporter.sv
hdl/test_sequencer.sv
hdl/sdram_burst_test.sv
dv/tb_mem_model.sv
dv/sdram_burst_test_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f sdram_burst_test.f --top-module sdram_burst_test_tb -Mdir obj_dir -o sim

out=$(./obj_dir/sim)
echo "$out"

grep -qF "*** TEST PASSED ***" <<< "$out"
